// ==== bench/rv_core_stimulus.txt ====
# p addr word = program word, d addr word = initial data word (hex)
# t name = start of a test, e addr data = next expected store of that test (hex)
p 000 FFB00093
p 004 00300113
p 008 002081B3
p 00C 40110233
p 010 0020A2B3
p 014 0020B333
p 018 4020D3B3
p 01C 0020D433
p 020 002114B3
p 024 0020C533
p 028 0020E5B3
p 02C 0020F633
p 030 001126B3
p 034 00113733
p 038 10302023
p 03C 10402223
p 040 10502423
p 044 10602623
p 048 10702823
p 04C 10802A23
p 050 10902C23
p 054 10A02E23
p 058 12B02023
p 05C 12C02223
p 060 12D02423
p 064 12E02623
p 068 FFC0A793
p 06C FFF13813
p 070 FFF0C893
p 074 7F016913
p 078 0FF0F993
p 07C 00411A13
p 080 01C0DA93
p 084 4010DB13
p 088 12F02823
p 08C 13002A23
p 090 13102C23
p 094 13202E23
p 098 15302023
p 09C 15402223
p 0A0 15502423
p 0A4 15602623
p 0A8 80001BB7
p 0AC 00001C17
p 0B0 00000C97
p 0B4 16000D13
p 0B8 FF7D2E23
p 0BC 018D2023
p 0C0 019D2223
p 0C4 20002083
p 0C8 20402103
p 0CC 002081B3
p 0D0 20302023
p 0D4 20002203
p 0D8 00120213
p 0DC 20402423
p 0E0 FFB00093
p 0E4 00300113
p 0E8 00A00E13
p 0EC 00B00E93
p 0F0 00208463
p 0F4 31C02023
p 0F8 31D02023
p 0FC 00209463
p 100 31C02023
p 104 31D02023
p 108 0020C463
p 10C 31C02023
p 110 31D02023
p 114 0020D463
p 118 31C02023
p 11C 31D02023
p 120 0020E463
p 124 31C02023
p 128 31D02023
p 12C 0020F463
p 130 31C02023
p 134 31D02023
p 138 00108463
p 13C 31C02023
p 140 31D02023
p 144 00109463
p 148 31C02023
p 14C 31D02023
p 150 0011C463
p 154 31C02023
p 158 31D02023
p 15C 0011D463
p 160 31C02023
p 164 31D02023
p 168 0011E463
p 16C 31C02023
p 170 31D02023
p 174 0011F463
p 178 31C02023
p 17C 31D02023
p 180 008002EF
p 184 41C02023
p 188 40502023
p 18C 19500313
p 190 004303E7
p 194 41C02023
p 198 40702223
p 19C 00500013
p 1A0 40002423
p 1A4 0000006F
d 200 12345678
d 204 00000010
t alu_reg
e 100 FFFFFFFE
e 104 00000008
e 108 00000001
e 10C 00000000
e 110 FFFFFFFF
e 114 1FFFFFFF
e 118 00000018
e 11C FFFFFFF8
e 120 FFFFFFFB
e 124 00000003
e 128 00000000
e 12C 00000001
t alu_imm
e 130 00000001
e 134 00000001
e 138 00000004
e 13C 000007F3
e 140 000000FB
e 144 00000030
e 148 0000000F
e 14C FFFFFFFD
t upper_imm
e 15C 80001000
e 160 000010AC
e 164 000000B0
t load_store
e 200 12345688
e 208 12345689
t branch
e 300 0000000A
e 300 0000000B
e 300 0000000B
e 300 0000000B
e 300 0000000A
e 300 0000000B
e 300 0000000A
e 300 0000000B
e 300 0000000B
e 300 0000000B
e 300 0000000A
e 300 0000000B
e 300 0000000A
e 300 0000000B
e 300 0000000B
e 300 0000000B
e 300 0000000A
e 300 0000000B
t jump
e 400 00000184
e 404 00000194
t x0_zero
e 408 00000000

// ==== filelist.f ====
hdl/rv_core_pkg.sv
hdl/rv_control_fsm.sv
hdl/rv_fetch_stage.sv
hdl/rv_decode_stage.sv
hdl/rv_execute_stage.sv
hdl/rv_memory_stage.sv
hdl/rv_core.sv
bench/rv_store_checker.sv
bench/rv_core_tb.sv

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb
    import rv_core_pkg::*;
();

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t imem [1024];
    word_t dmem [1024];

    logic checks_done;
    logic timed_out;
    logic loaded;
    logic load_ok;
    int   prog_words;

    rv_core DUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    rv_store_checker u_checker (
        .clk      (clk),
        .reset    (reset),
        .dmem_req (dmem_req),
        .done     (checks_done)
    );

    // Memory models, combinational read
    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[11:2]] : 'x;   // Valid under read only

    always @(posedge clk) begin
        if (dmem_req.write) begin
            dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task fill_memories();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = word_t'(i) << 7;   // Opcode field zero, runs as a no-op
            dmem[i] = 32'hA5A5_0000 ^ (word_t'(i) << 2);
        end
    endtask

    task flag_bad_line(input logic [8*16-1:0] line_kind);
        $display("Malformed %0s line in stimulus file", line_kind);
        load_ok = 1'b0;
    endtask

    task load_stimulus();
        integer          fd;
        integer          code;
        logic [8*16-1:0] kind;
        logic [8*16-1:0] name;
        logic [8*128-1:0] line;
        word_t           addr;
        word_t           data;
        fd = $fopen("bench/rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/rv_core_stimulus.txt");
            load_ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(line, fd);
                end else if (kind == "p") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    if (code != 2) begin
                        flag_bad_line(kind);
                    end else begin
                        imem[addr[11:2]] = data;
                        prog_words++;
                    end
                end else if (kind == "d") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    if (code != 2) begin
                        flag_bad_line(kind);
                    end else begin
                        dmem[addr[11:2]] = data;
                    end
                end else if (kind == "t") begin
                    code = $fscanf(fd, "%s", name);
                    if (code != 1) begin
                        flag_bad_line(kind);
                    end else begin
                        u_checker.add_test(name);
                    end
                end else if (kind == "e") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    if (code != 2) begin
                        flag_bad_line(kind);
                    end else begin
                        u_checker.add_store(addr, data);
                    end
                end else begin
                    $display("Unknown line kind %0s in stimulus file", kind);
                    load_ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    task finish_run(input logic failed);
        if (failed) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    endtask

    // 6 cycles per program word, times 8 for loops
    initial begin
        wait (loaded);
        #(prog_words * 6 * 8 * 4);
        timed_out = 1'b1;
    end

    initial begin
        reset      = 1'b1;
        timed_out  = 1'b0;
        loaded     = 1'b0;
        load_ok    = 1'b1;
        prog_words = 0;
        fill_memories();
        load_stimulus();
        if (!load_ok) begin
            finish_run(1'b1);
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            wait (checks_done || timed_out);
            @(negedge clk);
            u_checker.report_counts();
            if (timed_out) begin
                $display("Watchdog expired: test %0s never completed",
                         u_checker.pending_test());
            end
            finish_run(timed_out || u_checker.error_total() != 0);
        end
    end

endmodule

// ==== bench/rv_store_checker.sv ====
`timescale 1ns/100ps

module rv_store_checker
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  dmem_req_t dmem_req,
    output logic      done
);

    word_t           exp_addr [256];
    word_t           exp_data [256];
    logic [8*16-1:0] test_name [32];
    int              test_last [32];   // One past the last store of each test

    int num_exp     = 0;
    int num_tests   = 0;
    int store_idx   = 0;
    int cur_test    = 0;
    int cur_errors  = 0;
    int tests_done  = 0;
    int error_count = 0;

    assign done = (num_exp > 0) && (store_idx == num_exp);

    task add_test(input logic [8*16-1:0] name);
        test_name[num_tests] = name;
        test_last[num_tests] = num_exp;
        num_tests++;
    endtask

    task add_store(input word_t addr, input word_t data);
        exp_addr[num_exp] = addr;
        exp_data[num_exp] = data;
        num_exp++;
        test_last[num_tests-1] = num_exp;
    endtask

    function int error_total();
        return error_count;
    endfunction

    function logic [8*16-1:0] pending_test();
        if (cur_test < num_tests) begin
            return test_name[cur_test];
        end
        return "none";
    endfunction

    task check_store(input word_t addr, input word_t data);
        if (store_idx >= num_exp) begin
            $display("Unexpected extra store at time %0t: [%h] = %h", $time, addr, data);
            error_count++;
        end else begin
            if (addr !== exp_addr[store_idx] || data !== exp_data[store_idx]) begin
                $display("** Error at %0t: test %0s store %0d expected [%h] = %h, got [%h] = %h",
                         $time, test_name[cur_test], store_idx,
                         exp_addr[store_idx], exp_data[store_idx], addr, data);
                error_count++;
                cur_errors++;
            end
            store_idx++;
            // Last store of the current test
            if (store_idx == test_last[cur_test]) begin
                $display("test %0s finished at %0t with %0d error(s)",
                         test_name[cur_test], $time, cur_errors);
                tests_done++;
                cur_test++;
                cur_errors = 0;
            end
        end
    endtask

    task report_counts();
        $display("Tests completed %0d of %0d, stores checked %0d of %0d, errors %0d",
                 tests_done, num_tests, store_idx, num_exp, error_count);
    endtask

    // Strobes last a whole cycle, so mid-cycle sampling sees each once
    always @(negedge clk) begin
        if (reset) begin
            if (dmem_req.read || dmem_req.write) begin
                $display("Data strobe asserted during reset at time %0t", $time);
                error_count++;
            end
        end else if (dmem_req.write) begin
            check_store(dmem_req.addr, dmem_req.wdata);
        end
    end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    state_e    state;
    ctrl_t     ctrl;
    operands_t operands;
    logic      ir_load;
    logic      operand_load;
    logic      alu_load;
    logic      mdr_load;
    logic      mem_enable;
    logic      reg_write_en;
    logic      redirect;
    word_t     target;
    word_t     instr;
    word_t     instr_pc;
    word_t     pc;
    word_t     alu_out;
    word_t     wb_data;

    rv_control_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .state        (state),
        .ir_load      (ir_load),
        .operand_load (operand_load),
        .alu_load     (alu_load),
        .mdr_load     (mdr_load),
        .mem_enable   (mem_enable),
        .reg_write_en (reg_write_en)
    );

    rv_fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .ir_load   (ir_load),
        .redirect  (redirect),
        .target    (target),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .instr     (instr),
        .instr_pc  (instr_pc),
        .pc        (pc)
    );

    rv_decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .operand_load (operand_load),
        .reg_write_en (reg_write_en),
        .wb_data      (wb_data),
        .ctrl         (ctrl),
        .operands     (operands)
    );

    rv_execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .alu_load (alu_load),
        .state    (state),
        .ctrl     (ctrl),
        .operands (operands),
        .funct3   (instr[14:12]),
        .instr_pc (instr_pc),
        .alu_out  (alu_out),
        .redirect (redirect),
        .target   (target)
    );

    rv_memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .mem_enable (mem_enable),
        .mdr_load   (mdr_load),
        .ctrl       (ctrl),
        .alu_out    (alu_out),
        .store_data (operands.b),
        .pc         (pc),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb_data    (wb_data)
    );

endmodule

// ==== hdl/rv_memory_stage.sv ====
`timescale 1ns/100ps

module rv_memory_stage
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_enable,
    input  logic      mdr_load,
    input  ctrl_t     ctrl,
    input  word_t     alu_out,
    input  word_t     store_data,
    input  word_t     pc,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output word_t     wb_data
);

    word_t mdr;

    assign dmem_req.read  = mem_enable && ctrl.mem_read;
    assign dmem_req.write = mem_enable && ctrl.mem_write;
    assign dmem_req.addr  = alu_out;
    assign dmem_req.wdata = store_data;   // rs2 from the B register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mdr <= '0;
        end else if (mdr_load) begin
            mdr <= dmem_rdata;
        end
    end

    always_comb begin
        if (ctrl.mem_read) begin
            wb_data = mdr;
        end else if (ctrl.jump) begin
            wb_data = pc;         // Link value
        end else begin
            wb_data = alu_out;
        end
    end

    a_no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(dmem_req.read && dmem_req.write));

    // Strobes last one cycle
    a_write_single_cycle: assert property (@(posedge clk) disable iff (reset)
        dmem_req.write |=> !dmem_req.write);

endmodule

// ==== hdl/rv_execute_stage.sv ====
`timescale 1ns/100ps

module rv_execute_stage
    import rv_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       alu_load,
    input  state_e     state,
    input  ctrl_t      ctrl,
    input  operands_t  operands,
    input  logic [2:0] funct3,
    input  word_t      instr_pc,
    output word_t      alu_out,
    output logic       redirect,
    output word_t      target
);

    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t jalr_sum;
    logic  taken;

    always_comb begin
        if (ctrl.auipc) begin
            op_a = instr_pc;
        end else if (ctrl.lui) begin
            op_a = '0;
        end else begin
            op_a = operands.a;
        end
    end

    assign op_b = ctrl.use_imm ? operands.imm : operands.b;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result = word_t'(op_a < op_b);
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Branch conditions always compare rs1 against rs2
    always_comb begin
        case (funct3)
            3'b000:  taken = (operands.a == operands.b);
            3'b001:  taken = (operands.a != operands.b);
            3'b100:  taken = ($signed(operands.a) < $signed(operands.b));
            3'b101:  taken = ($signed(operands.a) >= $signed(operands.b));
            3'b110:  taken = (operands.a < operands.b);
            3'b111:  taken = (operands.a >= operands.b);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = operands.a + operands.imm;
    assign target   = ctrl.jalr ? {jalr_sum[31:1], 1'b0} : instr_pc + operands.imm;
    assign redirect = (state == st_execute) && (ctrl.jump || (ctrl.branch && taken));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_out <= '0;
        end else if (alu_load) begin
            alu_out <= alu_result;
        end
    end

endmodule

// ==== hdl/rv_decode_stage.sv ====
`timescale 1ns/100ps

module rv_decode_stage
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     instr,
    input  logic      operand_load,
    input  logic      reg_write_en,
    input  word_t     wb_data,
    output ctrl_t     ctrl,
    output operands_t operands
);

    opcode_e  opcode;
    logic     [2:0] funct3;
    reg_idx_t rs1;
    reg_idx_t rs2;
    alu_op_e  alu_sel;
    word_t    imm;
    word_t    regs [32];

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Shared by register and immediate forms; sub only exists for op_reg
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = instr[30] ? alu_sra : alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (opcode)
            op_reg: begin
                ctrl.alu_op    = alu_sel;
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = alu_sel;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_branch: ctrl.branch = 1'b1;
            op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_jalr: begin
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_lui: begin
                ctrl.lui       = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_auipc: begin
                ctrl.auipc     = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl.alu_op = alu_add;   // Unsupported opcode runs as a no-op
        endcase
        if (ctrl.reg_write) begin
            ctrl.rd = instr[11:7];
        end
    end

    // Immediate formats
    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: imm = {{20{instr[31]}}, instr[31:20]};
            op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            op_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            op_lui, op_auipc: imm = {instr[31:12], 12'b0};
            default:   imm = '0;
        endcase
    end

    // Register file, x0 never written
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write_en && ctrl.reg_write && ctrl.rd != '0) begin
            regs[ctrl.rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operands <= '0;
        end else if (operand_load) begin
            operands.a   <= regs[rs1];
            operands.b   <= regs[rs2];
            operands.imm <= imm;
        end
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (operand_load && rs1 == '0) |=> (operands.a == '0));

endmodule

// ==== hdl/rv_fetch_stage.sv ====
`timescale 1ns/100ps

module rv_fetch_stage
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  ir_load,
    input  logic  redirect,
    input  word_t target,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t instr,
    output word_t instr_pc,
    output word_t pc
);

    word_t pc_q;
    word_t ir_q;
    word_t instr_pc_q;
    word_t pc_plus4;

    assign pc_plus4 = pc_q + word_t'(4);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q       <= reset_pc;
            ir_q       <= '0;
            instr_pc_q <= '0;
        end else if (ir_load) begin
            ir_q       <= imem_data;
            instr_pc_q <= pc_q;       // Address of the instruction just fetched
            pc_q       <= pc_plus4;
        end else if (redirect) begin
            pc_q <= target;
        end
    end

    assign imem_addr = pc_q;
    assign instr     = ir_q;
    assign instr_pc  = instr_pc_q;

    // Sequential successor, unaffected by a later redirect
    assign pc = instr_pc_q + word_t'(4);

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc_q[1:0] == 2'b00);

endmodule

// ==== hdl/rv_control_fsm.sv ====
`timescale 1ns/100ps

module rv_control_fsm
    import rv_core_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  ctrl_t  ctrl,
    output state_e state,
    output logic   ir_load,
    output logic   operand_load,
    output logic   alu_load,
    output logic   mdr_load,
    output logic   mem_enable,
    output logic   reg_write_en
);

    state_e next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_fetch;
        case (state)
            st_fetch:  next_state = st_decode;
            st_decode: next_state = st_execute;
            st_execute: begin
                if (ctrl.mem_read || ctrl.mem_write) begin
                    next_state = st_memory;
                end else if (ctrl.reg_write) begin
                    next_state = st_writeback;
                end else begin
                    next_state = st_fetch;   // Branches and no-ops end here
                end
            end
            st_memory:    next_state = ctrl.mem_read ? st_writeback : st_fetch;
            st_writeback: next_state = st_fetch;
            default:      next_state = st_fetch;
        endcase
    end

    // One strobe per state
    assign ir_load      = (state == st_fetch);
    assign operand_load = (state == st_decode);
    assign alu_load     = (state == st_execute);
    assign mem_enable   = (state == st_memory);
    assign mdr_load     = (state == st_memory) && ctrl.mem_read;
    assign reg_write_en = (state == st_writeback);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {st_fetch, st_decode, st_execute, st_memory, st_writeback});

    // Memory cycle only for a decoded load or store
    a_memory_has_access: assert property (@(posedge clk) disable iff (reset)
        (state == st_memory) |-> (ctrl.mem_read || ctrl.mem_write));

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // RV32I major opcodes that the core executes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } state_e;

    // Decoded control word, valid for as long as IR holds the instruction
    typedef struct packed {
        alu_op_e  alu_op;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     use_imm;   // B operand is the immediate
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     lui;
        logic     auipc;
        reg_idx_t rd;
    } ctrl_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t imm;
    } operands_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage
